// File: rvPipeline.f
design/rvPkg.sv
design/instrDecoder.sv
design/regFile.sv
design/alu.sv
design/hazardUnit.sv
design/rvPipeline.sv
test/cacheModel.sv
test/rvPipelineTb.sv

// File: Makefile
SIM = obj_dir/rvPipelineSim

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run, look for the pass line"
	@echo "make clean  remove obj_dir"
	@echo "make help   list these targets"

test:
	verilator --binary --timing --assert -f rvPipeline.f \
		--top-module rvPipelineTb -o rvPipelineSim
	./$(SIM) | tee /dev/stderr | grep -q "TEST OK"

clean:
	rm -rf obj_dir

// File: test/rvPipelineTb.sv
`timescale 1ns/1ns

module rvPipelineTb import rvPkg::*; ();

    localparam int maxCycles  = 4000;
    localparam int poisonAddr = 200;   // only skipped instructions store here

    logic  clk, rst_n, stallOn;
    logic  iCacheStall, iCacheRen, dCacheStall, dCacheRen, dCacheWen;
    word_t iCacheRdata, iCacheAddr, dCacheRdata, dCacheAddr, dCacheWdata;

    word_t prog [128];
    word_t expAddr [64];
    word_t expData [64];
    word_t expAddrNow, expDataNow, firstStorePc, endPc;
    int    progLen, expCount, storeIdx, cycleCnt, addrCycle, passNo;
    logic  lastRst, addrSeen;

    rvPipeline DUT (
        .clk(clk), .rst_n(rst_n), .iCacheStall(iCacheStall), .iCacheRdata(iCacheRdata),
        .iCacheRen(iCacheRen), .iCacheAddr(iCacheAddr), .dCacheStall(dCacheStall),
        .dCacheRdata(dCacheRdata), .dCacheRen(dCacheRen), .dCacheWen(dCacheWen),
        .dCacheAddr(dCacheAddr), .dCacheWdata(dCacheWdata)
    );

    cacheModel caches (
        .clk(clk), .rst_n(rst_n), .stallOn(stallOn), .iCacheRen(iCacheRen),
        .iCacheAddr(iCacheAddr), .iCacheStall(iCacheStall), .iCacheRdata(iCacheRdata),
        .dCacheRen(dCacheRen), .dCacheWen(dCacheWen), .dCacheAddr(dCacheAddr),
        .dCacheWdata(dCacheWdata), .dCacheStall(dCacheStall), .dCacheRdata(dCacheRdata)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic failRun(string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "run stopped");
    endtask

    function automatic word_t encR(int f7, int rs2, int rs1, int f3, int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], opOp};
    endfunction

    function automatic word_t encI(int imm, int rs1, int f3, int rd, logic [6:0] op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic word_t encS(int imm, int rs2, int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], opStore};
    endfunction

    function automatic word_t encB(int off, int rs2, int rs1, int f3);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], opBranch};
    endfunction

    function automatic word_t encJ(int off, int rd);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], opJal};
    endfunction

    task automatic put(word_t w);
        prog[progLen] = w;
        progLen++;
    endtask

    task automatic buildProgram();
        int n;
        progLen = 0;
        put(encI(5, 0, 0, 1, opOpImm));      // x1 = 5
        put(encS(0, 1, 0));                  // first store, no hazard in front
        put(encI(-3, 1, 0, 2, opOpImm));
        put(encR(0, 2, 1, 0, 3));            // add, chain through MEM and WB
        put(encR(32, 1, 3, 0, 4));           // sub
        put(encR(0, 4, 3, 7, 5));
        put(encR(0, 2, 3, 6, 6));
        put(encR(0, 1, 6, 4, 7));
        put(encR(0, 3, 4, 2, 8));
        put(encI(-8, 0, 0, 10, opOpImm));
        put(encR(0, 1, 10, 2, 9));           // slt with a negative operand
        put(encR(0, 2, 1, 1, 11));
        put(encR(0, 2, 10, 5, 12));
        put(encR(32, 2, 10, 5, 13));         // sra
        put(encI(3, 1, 1, 20, opOpImm));
        put(encI(28, 10, 5, 21, opOpImm));
        put(encI(1024 + 1, 10, 5, 22, opOpImm));   // srai
        put(encI(6, 3, 7, 23, opOpImm));
        put(encI(8, 4, 6, 24, opOpImm));
        put(encI(-1, 1, 4, 25, opOpImm));
        put(encI(-7, 10, 2, 26, opOpImm));
        for (int r = 1; r <= 26; r++) begin
            if (r <= 13 || r >= 20) put(encS(4 * r, r, 0));
        end
        put(encI(8, 0, 2, 14, opLoad));
        put(encR(0, 14, 14, 0, 15));         // load-use
        put(encS(160, 15, 0));
        put(encI(0, 0, 2, 16, opLoad));
        put(encB(8, 1, 16, 0));              // beq on a fresh load, taken
        put(encS(poisonAddr, 1, 0));
        put(encB(8, 1, 16, 1));              // bne not taken
        put(encS(164, 16, 0));
        put(encB(8, 2, 1, 0));               // beq not taken
        put(encS(168, 2, 0));
        put(encJ(8, 17));
        put(encS(poisonAddr, 1, 0));
        put(encS(172, 17, 0));
        n = progLen;
        put(encI(4 * (n + 3), 0, 0, 18, opOpImm));
        put(encI(0, 18, 0, 19, opJalr));     // stalls on x18 in EX
        put(encS(poisonAddr, 1, 0));
        put(encS(176, 19, 0));
        put(encJ(0, 0));                     // park here
        for (int i = 0; i < 128; i++) begin
            caches.rom[i] = (i < progLen) ? prog[i] : '0;
        end
    endtask

    // reference result for one arithmetic op
    function automatic word_t calc(logic [2:0] f3, logic alt, word_t a, word_t b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            3'd7: return a & b;
            default: return '0;
        endcase
    endfunction

    // instruction-level run of the program to get the store list
    task automatic buildExpected();
        word_t      x [32];
        word_t      mem [64];
        word_t      pc, w, a, b, immI, immS, immB, immJ, nxt, addr;
        logic [6:0] op;
        logic [2:0] f3;
        int         rd;
        for (int i = 0; i < 64; i++) mem[i] = 32'h1357_0000 | (i * 4);
        for (int i = 0; i < 32; i++) x[i] = '0;
        pc = '0;
        expCount = 0;
        for (int step = 0; step < 1000; step++) begin
            w    = prog[pc[8:2]];
            op   = w[6:0];
            f3   = w[14:12];
            rd   = int'(w[11:7]);
            a    = x[w[19:15]];
            b    = x[w[24:20]];
            immI = {{20{w[31]}}, w[31:20]};
            immS = {{20{w[31]}}, w[31:25], w[11:7]};
            immB = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            immJ = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            nxt  = pc + 32'd4;
            if (op == opJal && immJ == '0) break;
            case (op)
                opOp:    x[rd] = calc(f3, w[30], a, b);
                opOpImm: x[rd] = calc(f3, f3 == 3'd5 && w[30], a, immI);
                opLoad: begin
                    addr  = a + immI;
                    x[rd] = mem[addr[7:2]];
                end
                opStore: begin
                    addr = a + immS;
                    mem[addr[7:2]] = b;
                    if (expCount == 0) firstStorePc = pc;
                    expAddr[expCount] = addr;
                    expData[expCount] = b;
                    expCount++;
                end
                opBranch: if ((a == b) != f3[0]) nxt = pc + immB;
                opJal: begin
                    x[rd] = pc + 32'd4;
                    nxt   = pc + immJ;
                end
                opJalr: begin
                    x[rd] = pc + 32'd4;
                    nxt   = (a + immI) & ~32'd1;
                end
                default: ;
            endcase
            x[0] = '0;
            pc   = nxt;
        end
        endPc = pc;
    endtask

    always_comb begin
        expAddrNow = expAddr[storeIdx[5:0]];
        expDataNow = expData[storeIdx[5:0]];
    end

    always @(posedge clk) begin
        cycleCnt <= cycleCnt + 1;
        lastRst  <= rst_n;
        if (cycleCnt >= maxCycles) failRun("timeout before program end");
        if (!rst_n) begin
            storeIdx <= 0;
        end else if (dCacheWen && !dCacheStall) begin
            storeIdx <= storeIdx + 1;
        end
        if (rst_n && !addrSeen && iCacheAddr == firstStorePc) begin
            addrSeen  <= 1'b1;
            addrCycle <= cycleCnt;
        end
    end

    resetState: assert property (@(posedge clk) !lastRst |->
        (iCacheAddr == '0 && !dCacheRen && !dCacheWen))
        else failRun($sformatf("error at %0t: reset state, pc %h", $time, iCacheAddr));

    // fetch strobe follows reset
    fetchEnable: assert property (@(posedge clk) iCacheRen == rst_n)
        else failRun($sformatf("error at %0t: iCacheRen %b while rst_n %b", $time, iCacheRen,
                               rst_n));

    storeMatch: assert property (@(posedge clk) disable iff (!rst_n)
        (dCacheWen && !dCacheStall) |->
        (storeIdx < expCount && dCacheAddr == expAddrNow && dCacheWdata == expDataNow))
        else failRun($sformatf("error at %0t: store %0d got %h <- %h, expected %h <- %h",
                               $time, storeIdx, dCacheAddr, dCacheWdata, expAddrNow,
                               expDataNow));

    noPoison: assert property (@(posedge clk) disable iff (!rst_n)
        dCacheWen |-> dCacheAddr != poisonAddr)
        else failRun($sformatf("error at %0t: store to the skipped-path address", $time));

    stallHold: assert property (@(posedge clk) disable iff (!rst_n)
        dCacheStall |=> $stable({dCacheRen, dCacheWen, dCacheAddr, dCacheWdata}))
        else failRun($sformatf("error at %0t: data request changed under a stall", $time));

    firstStoreTiming: assert property (@(posedge clk) disable iff (!rst_n)
        (passNo == 0 && addrSeen && storeIdx == 0 && dCacheWen) |-> cycleCnt == addrCycle + 3)
        else failRun($sformatf("error at %0t: first store %0d cycles after its fetch",
                               $time, cycleCnt - addrCycle));

    initial begin
        rst_n    = 1'b0;
        stallOn  = 1'b0;
        lastRst  = 1'b1;
        addrSeen = 1'b0;
        cycleCnt = 0;
        storeIdx = 0;
        passNo   = 0;
        buildProgram();
        buildExpected();
        for (int pass = 0; pass < 2; pass++) begin
            passNo  = pass;
            rst_n   = 1'b0;
            stallOn = (pass == 1);   // second pass runs with random stalls
            repeat (8) @(posedge clk);
            #1 rst_n = 1'b1;
            while (!(storeIdx == expCount && iCacheAddr == endPc)) @(posedge clk);
            @(posedge clk);
            #1;
        end
        $display("TEST OK");
        $finish;
    end

endmodule

// File: test/cacheModel.sv
`timescale 1ns/1ns

module cacheModel import rvPkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  stallOn,      // random stalls enabled
    input  logic  iCacheRen,
    input  word_t iCacheAddr,
    output logic  iCacheStall,
    output word_t iCacheRdata,
    input  logic  dCacheRen,
    input  logic  dCacheWen,
    input  word_t dCacheAddr,
    input  word_t dCacheWdata,
    output logic  dCacheStall,
    output word_t dCacheRdata
);

    word_t rom [128];
    word_t ram [64];
    int    seed = 17;

    initial begin
        iCacheStall = 1'b0;
        dCacheStall = 1'b0;
    end

    // stall levels move just after the edge, about one cycle in four
    always @(posedge clk) begin
        #1;
        iCacheStall <= stallOn && (($random(seed) & 3) == 0);
        dCacheStall <= stallOn && (($random(seed) & 3) == 0);
    end

    // same-cycle answer, data ignored by the core while stalled
    assign iCacheRdata = (iCacheRen && !iCacheStall) ? rom[iCacheAddr[8:2]] : '0;
    assign dCacheRdata = (dCacheRen && !dCacheStall) ? ram[dCacheAddr[7:2]] : '0;

    always @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 64; i++) begin
                ram[i] <= 32'h1357_0000 | (i * 4);   // pattern over the full word index
            end
        end else if (dCacheWen && !dCacheStall) begin
            ram[dCacheAddr[7:2]] <= dCacheWdata;
        end
    end

endmodule

// File: design/rvPipeline.sv
`timescale 1ns/1ns

module rvPipeline import rvPkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  iCacheStall,
    input  word_t iCacheRdata,
    output logic  iCacheRen,
    output word_t iCacheAddr,
    input  logic  dCacheStall,
    input  word_t dCacheRdata,
    output logic  dCacheRen,
    output logic  dCacheWen,
    output word_t dCacheAddr,
    output word_t dCacheWdata
);

    word_t             pc, pcNext;
    word_t             ifIdPc;
    logic [instrW-1:0] ifIdInstr;

    ctrl_t   idCtrl;
    word_t   idImm, rData1, rData2, idOp1, idOp2, targetSum, redirectPc;
    regIdx_t idRs1, idRs2, idRd;
    logic    idUsesRs2, idNeedsEarly, brTaken;

    ctrl_t   idExCtrl;
    word_t   idExPc, idExRs1Val, idExRs2Val, idExImm;
    regIdx_t idExRs1, idExRs2, idExRd;
    word_t   exOpA, exRs2Fwd, aluB, aluY, exResult;

    ctrl_t   exMemCtrl, memWbCtrl;
    word_t   exMemResult, exMemStoreData, memWbResult, memWbLoadData, wbData;
    regIdx_t exMemRd, memWbRd;

    fwdSel_t fwdEx1, fwdEx2, fwdId1, fwdId2;
    logic    loadUseStall, branchStall, hazStall, fetchStall, redirect, ifIdLoad;

    // decode
    assign idRs1 = ifIdInstr[19:15];
    assign idRs2 = ifIdInstr[24:20];
    assign idRd  = ifIdInstr[11:7];

    instrDecoder uDec (.instr(ifIdInstr), .ctrl(idCtrl), .imm(idImm));

    regFile uRf (
        .clk(clk), .rst_n(rst_n), .rs1(idRs1), .rs2(idRs2), .rd(memWbRd),
        .we(memWbCtrl.regWrite), .wData(wbData), .rData1(rData1), .rData2(rData2)
    );

    assign idUsesRs2 = idCtrl.memWrite || idCtrl.branch
                       || (idCtrl.regWrite && !idCtrl.aluSrc && !idCtrl.jal);
    assign idNeedsEarly = idCtrl.branch || idCtrl.jalr;

    hazardUnit uHaz (
        .exRs1(idExRs1), .exRs2(idExRs2), .idRs1(idRs1), .idRs2(idRs2),
        .exRd(idExRd), .memRd(exMemRd), .wbRd(memWbRd),
        .exRegWrite(idExCtrl.regWrite), .exMemRead(idExCtrl.memRead),
        .memRegWrite(exMemCtrl.regWrite), .memMemRead(exMemCtrl.memRead),
        .wbRegWrite(memWbCtrl.regWrite), .idUsesRs2(idUsesRs2),
        .idNeedsEarly(idNeedsEarly), .fwdEx1(fwdEx1), .fwdEx2(fwdEx2),
        .fwdId1(fwdId1), .fwdId2(fwdId2), .loadUseStall(loadUseStall),
        .branchStall(branchStall)
    );

    // branch operands, a load in MEM never gets here
    assign idOp1 = (fwdId1 == fwdMem) ? exMemResult : (fwdId1 == fwdWb) ? wbData : rData1;
    assign idOp2 = (fwdId2 == fwdMem) ? exMemResult : (fwdId2 == fwdWb) ? wbData : rData2;

    assign brTaken    = idCtrl.branch && ((idOp1 == idOp2) ^ ifIdInstr[12]);  // funct3[0] is bne
    assign targetSum  = (idCtrl.jalr ? idOp1 : ifIdPc) + idImm;
    assign redirectPc = {targetSum[xlen-1:1], 1'b0};

    assign hazStall   = loadUseStall || branchStall;
    assign fetchStall = iCacheStall;
    assign redirect   = !hazStall && (idCtrl.jal || idCtrl.jalr || brTaken);
    assign ifIdLoad   = !hazStall && !redirect && !fetchStall;

    always_comb begin
        if (hazStall) pcNext = pc;
        else if (redirect) pcNext = redirectPc;
        else if (fetchStall) pcNext = pc;
        else pcNext = pc + 32'd4;
    end

    // execute
    assign exOpA    = (fwdEx1 == fwdMem) ? exMemResult : (fwdEx1 == fwdWb) ? wbData : idExRs1Val;
    assign exRs2Fwd = (fwdEx2 == fwdMem) ? exMemResult : (fwdEx2 == fwdWb) ? wbData : idExRs2Val;
    assign aluB     = idExCtrl.aluSrc ? idExImm : exRs2Fwd;

    alu uAlu (.a(exOpA), .b(aluB), .op(idExCtrl.aluOp), .y(aluY));

    assign exResult = (idExCtrl.jal || idExCtrl.jalr) ? idExPc + 32'd4 : aluY;  // link value

    assign wbData = memWbCtrl.memToReg ? memWbLoadData : memWbResult;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc        <= '0;
            ifIdInstr <= '0;
            idExCtrl  <= '0;
            exMemCtrl <= '0;
            memWbCtrl <= '0;
        end else if (!dCacheStall) begin   // data cache stall freezes everything
            pc      <= pcNext;
            if (ifIdLoad) ifIdInstr <= iCacheRdata;
            else if (!hazStall) ifIdInstr <= '0;   // flush or missing fetch
            idExCtrl  <= hazStall ? ctrl_t'('0) : idCtrl;
            exMemCtrl <= idExCtrl;
            memWbCtrl <= exMemCtrl;
        end
    end

    always_ff @(posedge clk) begin
        if (!dCacheStall) begin
            if (ifIdLoad) ifIdPc <= pc;
            idExPc         <= ifIdPc;
            idExRs1Val     <= rData1;
            idExRs2Val     <= rData2;
            idExImm        <= idImm;
            idExRs1        <= idRs1;
            idExRs2        <= idRs2;
            idExRd         <= idRd;
            exMemResult    <= exResult;
            exMemStoreData <= exRs2Fwd;
            exMemRd        <= idExRd;
            memWbResult    <= exMemResult;
            memWbLoadData  <= dCacheRdata;
            memWbRd        <= exMemRd;
        end
    end

    assign iCacheRen   = rst_n;
    assign iCacheAddr  = pc;
    assign dCacheRen   = exMemCtrl.memRead;
    assign dCacheWen   = exMemCtrl.memWrite;
    assign dCacheAddr  = exMemResult;
    assign dCacheWdata = exMemStoreData;

    dStrobeExcl: assert property (@(posedge clk) disable iff (!rst_n) !(dCacheRen && dCacheWen))
        else $error("dCacheRen and dCacheWen high together");

endmodule

// File: design/hazardUnit.sv
`timescale 1ns/1ns

module hazardUnit import rvPkg::*; (
    input  regIdx_t exRs1,
    input  regIdx_t exRs2,
    input  regIdx_t idRs1,
    input  regIdx_t idRs2,
    input  regIdx_t exRd,
    input  regIdx_t memRd,
    input  regIdx_t wbRd,
    input  logic    exRegWrite,
    input  logic    exMemRead,
    input  logic    memRegWrite,
    input  logic    memMemRead,
    input  logic    wbRegWrite,
    input  logic    idUsesRs2,
    input  logic    idNeedsEarly,   // branch or jalr resolved in decode
    output fwdSel_t fwdEx1,
    output fwdSel_t fwdEx2,
    output fwdSel_t fwdId1,
    output fwdSel_t fwdId2,
    output logic    loadUseStall,
    output logic    branchStall
);

    logic exHit1;
    logic exHit2;
    logic memLoadHit;

    // MEM result wins over WB, x0 never forwards
    function automatic fwdSel_t pickFwd(regIdx_t src, logic memWe, regIdx_t memDst,
                                        logic wbWe, regIdx_t wbDst);
        if (memWe && memDst != '0 && memDst == src) begin
            return fwdMem;
        end else if (wbWe && wbDst != '0 && wbDst == src) begin
            return fwdWb;
        end
        return fwdNone;
    endfunction

    always_comb begin
        fwdEx1 = pickFwd(exRs1, memRegWrite, memRd, wbRegWrite, wbRd);
        fwdEx2 = pickFwd(exRs2, memRegWrite, memRd, wbRegWrite, wbRd);
        fwdId1 = pickFwd(idRs1, memRegWrite, memRd, wbRegWrite, wbRd);
        fwdId2 = pickFwd(idRs2, memRegWrite, memRd, wbRegWrite, wbRd);
    end

    // instruction in EX writes a register that decode reads
    assign exHit1 = exRegWrite && exRd != '0 && exRd == idRs1;
    assign exHit2 = exRegWrite && exRd != '0 && exRd == idRs2 && idUsesRs2;

    // load data only shows up in WB
    assign memLoadHit = memMemRead && memRd != '0
                        && (memRd == idRs1 || (idUsesRs2 && memRd == idRs2));

    assign loadUseStall = exMemRead && (exHit1 || exHit2);
    assign branchStall  = idNeedsEarly && (exHit1 || exHit2 || memLoadHit);

    always_comb begin
        assert final ((fwdEx1 == fwdNone || exRs1 != '0) && (fwdEx2 == fwdNone || exRs2 != '0)
                      && (fwdId1 == fwdNone || idRs1 != '0)
                      && (fwdId2 == fwdNone || idRs2 != '0))
            else $error("forward select points at x0");
    end

endmodule

// File: design/alu.sv
`timescale 1ns/1ns

module alu import rvPkg::*; (
    input  word_t  a,
    input  word_t  b,
    input  aluOp_t op,
    output word_t  y
);

    logic [4:0] shamt;
    logic       lessThan;

    assign shamt    = b[4:0];
    assign lessThan = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            aluAdd:  y = a + b;
            aluSub:  y = a - b;
            aluAnd:  y = a & b;
            aluOr:   y = a | b;
            aluXor:  y = a ^ b;
            aluSlt:  y = {{(xlen-1){1'b0}}, lessThan};
            aluSll:  y = a << shamt;
            aluSrl:  y = a >> shamt;
            // sign bit shifted in
            aluSra:  y = word_t'($signed(a) >>> shamt);
            default: y = '0;
        endcase
    end

endmodule

// File: design/regFile.sv
`timescale 1ns/1ns

module regFile import rvPkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  regIdx_t rs1,
    input  regIdx_t rs2,
    input  regIdx_t rd,
    input  logic    we,
    input  word_t   wData,
    output word_t   rData1,
    output word_t   rData2
);

    word_t regs [numRegs];
    logic  wrLive;   // write that really lands this cycle

    assign wrLive = we && (rd != '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (wrLive) begin
            regs[rd] <= wData;
        end
    end

    // write-through so decode sees the value retiring in WB
    assign rData1 = (wrLive && rd == rs1) ? wData : regs[rs1];
    assign rData2 = (wrLive && rd == rs2) ? wData : regs[rs2];

    x0StaysZero: assert property (@(posedge clk) disable iff (!rst_n) regs[0] == '0)
        else $error("x0 holds a nonzero value");

endmodule

// File: design/instrDecoder.sv
`timescale 1ns/1ns

module instrDecoder import rvPkg::*; (
    input  word_t instr,
    output ctrl_t ctrl,
    output word_t imm
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7b5;   // instr[30] picks sub and sra
    logic       signBit;
    aluOp_t     arithOp;

    assign opcode   = instr[6:0];
    assign funct3   = instr[14:12];
    assign funct7b5 = instr[30];
    assign signBit  = instr[instrW-1];

    // shared by register and immediate arithmetic
    always_comb begin
        case (funct3)
            3'b000:  arithOp = (funct7b5 && opcode == opOp) ? aluSub : aluAdd;
            3'b001:  arithOp = aluSll;
            3'b010:  arithOp = aluSlt;
            3'b100:  arithOp = aluXor;
            3'b101:  arithOp = funct7b5 ? aluSra : aluSrl;
            3'b110:  arithOp = aluOr;
            3'b111:  arithOp = aluAnd;
            default: arithOp = aluAdd;  // sltu not implemented
        endcase
    end

    always_comb begin
        ctrl = '0;
        imm  = '0;
        case (opcode)
            opOp: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = arithOp;
            end
            opOpImm: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = arithOp;
                imm = {{20{signBit}}, instr[31:20]};   // shifts only use low 5 bits
            end
            opLoad: begin
                ctrl.regWrite = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = aluAdd;
                imm = {{20{signBit}}, instr[31:20]};
            end
            opStore: begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = aluAdd;
                imm = {{20{signBit}}, instr[31:25], instr[11:7]};
            end
            opBranch: begin
                ctrl.branch = 1'b1;
                ctrl.aluOp  = aluSub;
                imm = {{19{signBit}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            opJal: begin
                ctrl.regWrite = 1'b1;
                ctrl.jal      = 1'b1;
                imm = {{11{signBit}}, instr[31], instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            end
            opJalr: begin
                ctrl.regWrite = 1'b1;
                ctrl.jalr     = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = aluAdd;
                imm = {{20{signBit}}, instr[31:20]};
            end
            default: begin
                ctrl = '0;   // unknown opcode decodes as a bubble
            end
        endcase
    end

    // the data cache strobes come straight from these two bits in MEM
    always_comb begin
        assert final (!(ctrl.memRead && ctrl.memWrite))
            else $error("decoder raised memRead and memWrite together");
    end

endmodule

// File: design/rvPkg.sv
package rvPkg;

    localparam int xlen     = 32;   // data path and address width
    localparam int regAddrW = 5;
    localparam int numRegs  = 32;
    localparam int instrW   = 32;

    // major opcodes in instr[6:0]
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opOp     = 7'b0110011;
    localparam logic [6:0] opOpImm  = 7'b0010011;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;

    typedef logic [xlen-1:0]     word_t;
    typedef logic [regAddrW-1:0] regIdx_t;

    typedef enum logic [3:0] {
        aluAdd = 4'd0,
        aluSub = 4'd1,
        aluAnd = 4'd2,
        aluOr  = 4'd3,
        aluXor = 4'd4,
        aluSlt = 4'd5,   // signed compare
        aluSll = 4'd6,
        aluSrl = 4'd7,
        aluSra = 4'd8
    } aluOp_t;

    // operand source for the EX and decode muxes
    typedef enum logic [1:0] {
        fwdNone = 2'd0,  // register file value
        fwdWb   = 2'd1,
        fwdMem  = 2'd2
    } fwdSel_t;

    // control bundle carried down the pipe
    // all zero is a bubble
    typedef struct packed {
        logic   regWrite;
        logic   memRead;
        logic   memWrite;
        logic   memToReg;   // writeback takes load data
        logic   aluSrc;     // immediate as second operand
        logic   branch;     // beq or bne
        logic   jal;
        logic   jalr;
        aluOp_t aluOp;
    } ctrl_t;

endpackage
